// File: source/md_bus_settings.svh
// data-bus build settings
// lane count, lane and address widths, FM sample midpoint

`ifndef MD_BUS_SETTINGS_SVH
`define MD_BUS_SETTINGS_SVH

// byte lanes on the 68k-side data bus
`define MD_LANES 2

// width of one lane
`define MD_LANE_W 8

// work-RAM word address width
`define MD_RAM_AW 15

// midpoint of the unsigned linear FM sample
`define MD_FM_OFFSET 256

`endif

// File: source/md_bus_pkg.sv
// data-bus types
// vector typedefs for bus, address and audio widths, plus driver structs

`include "md_bus_settings.svh"

package md_bus_pkg;

	typedef logic [`MD_LANE_W-1:0]              bus_byte_t;
	typedef logic [`MD_LANES*`MD_LANE_W-1:0]    bus_word_t;
	typedef logic [22:0]                        cpu_addr_t;
	typedef logic [`MD_RAM_AW-1:0]              ram_addr_t;

	// FM linear is unsigned, DAC emulation is two's complement
	typedef logic [8:0]  fm_linear_t;
	typedef logic [9:0]  fm_dac_t;
	typedef logic [15:0] psg_t;
	typedef logic [15:0] mix_t;
	typedef logic [17:0] mix_dac_t;

	// word driver, enable is active low
	typedef struct packed {
		bus_word_t data;
		logic      drive_n;
	} bus_source_t;

	// per-lane active-high drive enables
	typedef struct packed {
		logic vdp;
		logic cpu;
		logic ram;
		logic cart;
	} lane_drive_t;

endpackage

// File: source/lane_enable_decode.sv
// lane enable decoder
// registers the cartridge mode and turns the raw driver enables
// into one set of active-high drive enables per byte lane

`timescale 1ns/1ps

`include "md_bus_settings.svh"

module lane_enable_decode
	import md_bus_pkg::*;
(
	input  logic                          MCLK2,
	input  logic                          rst_n_i,
	input  logic                          vdp_drive_n_i,
	input  logic                          cpu_drive_n_i,
	input  logic                          eoe_n_i,
	input  logic                          noe_n_i,
	input  logic                          ras0_n_i,
	input  logic                          cart_data_en_i,
	input  logic                          m3_i,
	output lane_drive_t [`MD_LANES-1:0]   lane_drive_o
);

	logic m3_q;

	// cartridge mode sampled once per clock
	always_ff @(posedge MCLK2)
	begin
		if (!rst_n_i)
			m3_q <= 1'b0;
		else
			m3_q <= m3_i;
	end

	always_comb
	begin
		// video and cpu always drive whole words
		for (int i = 0; i < `MD_LANES; i++)
		begin
			lane_drive_o[i].vdp = ~vdp_drive_n_i;
			lane_drive_o[i].cpu = ~cpu_drive_n_i;
		end

		// ram byte outputs, gated by the row strobe
		lane_drive_o[1].ram = ~eoe_n_i & ~ras0_n_i;
		lane_drive_o[0].ram = ~noe_n_i & ~ras0_n_i;

		// 8-bit cartridges only drive the low byte
		lane_drive_o[0].cart = cart_data_en_i;
		lane_drive_o[1].cart = cart_data_en_i & m3_q;
	end

endmodule

// File: source/data_bus_lane.sv
// data bus byte lane
// registered wired-OR of the enabled drivers, holds when undriven

`timescale 1ns/1ps

`include "md_bus_settings.svh"

module data_bus_lane
	import md_bus_pkg::*;
(
	input  logic        MCLK2,
	input  logic        rst_n_i,
	input  lane_drive_t lane_drive_i,
	input  bus_byte_t   vdp_byte_i,
	input  bus_byte_t   cpu_byte_i,
	input  bus_byte_t   ram_byte_i,
	input  bus_byte_t   cart_byte_i,
	output bus_byte_t   lane_o
);

	bus_byte_t merged;
	bus_byte_t lane_q;
	logic      any_drive;

	assign any_drive = |lane_drive_i;

	// every enabled driver contributes its bits
	always_comb
	begin
		merged = ({`MD_LANE_W{lane_drive_i.vdp}}  & vdp_byte_i)
		       | ({`MD_LANE_W{lane_drive_i.cpu}}  & cpu_byte_i)
		       | ({`MD_LANE_W{lane_drive_i.ram}}  & ram_byte_i)
		       | ({`MD_LANE_W{lane_drive_i.cart}} & cart_byte_i);
	end

	always_ff @(posedge MCLK2)
	begin
		if (!rst_n_i)
			lane_q <= '0;
		else if (any_drive)
			lane_q <= merged;
	end

	assign lane_o = lane_q;

endmodule

// File: source/work_ram_port.sv
// work RAM port
// builds the work-RAM address, byte enables, write enable and data
// from the resolved bus, the cpu address and the write strobes

`timescale 1ns/1ps

module work_ram_port
	import md_bus_pkg::*;
(
	input  bus_word_t  data_bus_i,
	input  cpu_addr_t  va_i,
	input  logic       ia14_i,
	input  logic       uwr_n_i,
	input  logic       lwr_n_i,
	input  logic       ras0_n_i,
	output ram_addr_t  ram_addr_o,
	output logic [1:0] ram_byteena_o,
	output logic       ram_wren_o,
	output bus_word_t  ram_data_o,
	output bus_word_t  cart_data_wr_o
);

	logic any_wr;

	// bit 13 of the ram address comes from the bus arbiter, not the cpu
	assign ram_addr_o = {va_i[14], ia14_i, va_i[12:0]};

	// upper strobe on enable 1, lower on enable 0
	assign ram_byteena_o = {~uwr_n_i, ~lwr_n_i};

	assign any_wr = ~uwr_n_i | ~lwr_n_i;

	// only during a ram row cycle
	assign ram_wren_o = any_wr & ~ras0_n_i;

	// both write paths see the resolved bus
	assign ram_data_o     = data_bus_i;
	assign cart_data_wr_o = data_bus_i;

endmodule

// File: source/audio_mixer.sv
// audio mixer
// adds the PSG sample to the FM output, both as linear FM
// and as the signed DAC-emulation FM, for left and right

`timescale 1ns/1ps

`include "md_bus_settings.svh"

module audio_mixer
	import md_bus_pkg::*;
(
	input  fm_linear_t mol_i,
	input  fm_linear_t mor_i,
	input  fm_dac_t    mol_dac_i,
	input  fm_dac_t    mor_dac_i,
	input  psg_t       psg_i,
	output mix_t       a_l_o,
	output mix_t       a_r_o,
	output mix_dac_t   a_l_dac_o,
	output mix_dac_t   a_r_dac_o
);

	// recentre around zero, then scale by 64
	function automatic mix_t mix_linear(input fm_linear_t fm, input psg_t psg);
		fm_linear_t centred;
		centred = fm - fm_linear_t'(`MD_FM_OFFSET);
		return {centred[8], centred, 6'b0} + psg;
	endfunction

	// signed sample times 192, as 128 plus 64
	function automatic mix_dac_t mix_dac(input fm_dac_t fm, input psg_t psg);
		mix_dac_t fm_ext;
		fm_ext = {{8{fm[9]}}, fm};
		return (fm_ext << 7) + (fm_ext << 6) + {2'b00, psg};
	endfunction

	assign a_l_o = mix_linear(mol_i, psg_i);
	assign a_r_o = mix_linear(mor_i, psg_i);

	// psg is unsigned here
	assign a_l_dac_o = mix_dac(mol_dac_i, psg_i);
	assign a_r_dac_o = mix_dac(mor_dac_i, psg_i);

endmodule

// File: source/md_bus_top.sv
// 68k-side data bus top level
// resolves the shared data bus per byte lane, forms the work-RAM
// write port and mixes the FM and PSG audio

`timescale 1ns/1ps

`include "md_bus_settings.svh"

module md_bus_top
	import md_bus_pkg::*;
(
	input  logic        MCLK2,
	input  logic        rst_n_i,

	// bus drivers
	input  bus_source_t vdp_src_i,
	input  bus_source_t cpu_src_i,
	input  bus_word_t   ram_q_i,
	input  logic        eoe_n_i,
	input  logic        noe_n_i,
	input  logic        ras0_n_i,
	input  bus_word_t   cart_data_i,
	input  logic        cart_data_en_i,
	input  logic        m3_i,

	// address and write strobes
	input  cpu_addr_t   va_i,
	input  logic        ia14_i,
	input  logic        uwr_n_i,
	input  logic        lwr_n_i,

	// audio sources
	input  fm_linear_t  mol_i,
	input  fm_linear_t  mor_i,
	input  fm_dac_t     mol_dac_i,
	input  fm_dac_t     mor_dac_i,
	input  psg_t        psg_i,

	output bus_word_t   data_bus_o,
	output ram_addr_t   ram_addr_o,
	output logic [1:0]  ram_byteena_o,
	output logic        ram_wren_o,
	output bus_word_t   ram_data_o,
	output bus_word_t   cart_data_wr_o,
	output mix_t        a_l_o,
	output mix_t        a_r_o,
	output mix_dac_t    a_l_dac_o,
	output mix_dac_t    a_r_dac_o
);

	lane_drive_t [`MD_LANES-1:0] lane_drive;
	bus_byte_t   [`MD_LANES-1:0] lane_byte;

	lane_enable_decode u_decode (
		.MCLK2          (MCLK2),
		.rst_n_i        (rst_n_i),
		.vdp_drive_n_i  (vdp_src_i.drive_n),
		.cpu_drive_n_i  (cpu_src_i.drive_n),
		.eoe_n_i        (eoe_n_i),
		.noe_n_i        (noe_n_i),
		.ras0_n_i       (ras0_n_i),
		.cart_data_en_i (cart_data_en_i),
		.m3_i           (m3_i),
		.lane_drive_o   (lane_drive)
	);

	// lane 0 is the low byte
	for (genvar i = 0; i < `MD_LANES; i++)
	begin : gen_lane
		data_bus_lane u_lane (
			.MCLK2        (MCLK2),
			.rst_n_i      (rst_n_i),
			.lane_drive_i (lane_drive[i]),
			.vdp_byte_i   (vdp_src_i.data[i*`MD_LANE_W +: `MD_LANE_W]),
			.cpu_byte_i   (cpu_src_i.data[i*`MD_LANE_W +: `MD_LANE_W]),
			.ram_byte_i   (ram_q_i[i*`MD_LANE_W +: `MD_LANE_W]),
			.cart_byte_i  (cart_data_i[i*`MD_LANE_W +: `MD_LANE_W]),
			.lane_o       (lane_byte[i])
		);
	end

	assign data_bus_o = lane_byte;

	work_ram_port u_ram_port (
		.data_bus_i     (data_bus_o),
		.va_i           (va_i),
		.ia14_i         (ia14_i),
		.uwr_n_i        (uwr_n_i),
		.lwr_n_i        (lwr_n_i),
		.ras0_n_i       (ras0_n_i),
		.ram_addr_o     (ram_addr_o),
		.ram_byteena_o  (ram_byteena_o),
		.ram_wren_o     (ram_wren_o),
		.ram_data_o     (ram_data_o),
		.cart_data_wr_o (cart_data_wr_o)
	);

	audio_mixer u_mixer (
		.mol_i     (mol_i),
		.mor_i     (mor_i),
		.mol_dac_i (mol_dac_i),
		.mor_dac_i (mor_dac_i),
		.psg_i     (psg_i),
		.a_l_o     (a_l_o),
		.a_r_o     (a_r_o),
		.a_l_dac_o (a_l_dac_o),
		.a_r_dac_o (a_r_dac_o)
	);

endmodule

// File: verification/md_bus_tb.sv
// data-bus top level testbench
// directed tests for bus resolution, cartridge mode, RAM port and audio mix

`timescale 1ns/1ps

`include "md_bus_settings.svh"

module md_bus_tb
	import md_bus_pkg::*;
();

	logic        MCLK2;
	logic        rst_n_i;
	bus_source_t vdp_src_i;
	bus_source_t cpu_src_i;
	bus_word_t   ram_q_i;
	logic        eoe_n_i;
	logic        noe_n_i;
	logic        ras0_n_i;
	bus_word_t   cart_data_i;
	logic        cart_data_en_i;
	logic        m3_i;
	cpu_addr_t   va_i;
	logic        ia14_i;
	logic        uwr_n_i;
	logic        lwr_n_i;
	fm_linear_t  mol_i;
	fm_linear_t  mor_i;
	fm_dac_t     mol_dac_i;
	fm_dac_t     mor_dac_i;
	psg_t        psg_i;

	bus_word_t   data_bus_o;
	ram_addr_t   ram_addr_o;
	logic [1:0]  ram_byteena_o;
	logic        ram_wren_o;
	bus_word_t   ram_data_o;
	bus_word_t   cart_data_wr_o;
	mix_t        a_l_o;
	mix_t        a_r_o;
	mix_dac_t    a_l_dac_o;
	mix_dac_t    a_r_dac_o;

	integer seed;
	int     errors;
	int     checks;

	md_bus_top UUT (.*);

	initial MCLK2 = 1'b0;
	always #20 MCLK2 = ~MCLK2;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic bus_word_t random_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// call right after a rising edge
	task automatic release_drivers();
		vdp_src_i.drive_n <= 1'b1;
		cpu_src_i.drive_n <= 1'b1;
		eoe_n_i <= 1'b1;
		noe_n_i <= 1'b1;
		ras0_n_i <= 1'b1;
		cart_data_en_i <= 1'b0;
	endtask

	task automatic wait_for_bus(input string name, input bus_word_t expected,
		input int limit, output int cycles);
		cycles = 0;
		do
		begin
			@(posedge MCLK2);
			cycles++;
			@(negedge MCLK2);
		end
		while (data_bus_o !== expected && cycles < limit);
		if (data_bus_o !== expected)
		begin
			errors++;
			$display("Timeout in %s: data bus did not reach %h within %0d cycles",
				name, expected, limit);
		end
	endtask

	// reference mix rules
	function automatic mix_t linear_ref(input fm_linear_t fm, input psg_t psg);
		int value;
		value = (int'(fm) - `MD_FM_OFFSET) * 64 + int'(psg);
		return value[15:0];
	endfunction

	function automatic mix_dac_t dac_ref(input fm_dac_t fm, input psg_t psg);
		int sample;
		int value;
		sample = int'(fm);
		if (fm[9])
			sample = sample - 1024;
		value = sample * 192 + int'(psg);
		return value[17:0];
	endfunction

	task automatic reset_state();
		@(negedge MCLK2);
		check_value("reset data bus", 32'h0, 32'(data_bus_o));
		check_value("reset ram write enable", 32'h0, 32'(ram_wren_o));
	endtask

	// one word for one cycle, then several idle cycles
	task automatic word_drive_hold(input string name, input bit use_cpu);
		bus_word_t w;
		w = random_word();
		@(posedge MCLK2);
		if (use_cpu)
		begin
			cpu_src_i.data <= w;
			cpu_src_i.drive_n <= 1'b0;
		end
		else
		begin
			vdp_src_i.data <= w;
			vdp_src_i.drive_n <= 1'b0;
		end
		@(posedge MCLK2);
		release_drivers();
		@(negedge MCLK2);
		check_value(name, 32'(w), 32'(data_bus_o));
		for (int i = 0; i < 4; i++)
		begin
			@(negedge MCLK2);
			check_value({name, " hold"}, 32'(w), 32'(data_bus_o));
		end
	endtask

	task automatic single_driver_hold();
		word_drive_hold("video drive", 1'b0);
		word_drive_hold("cpu drive", 1'b1);
	endtask

	task automatic ram_byte_lanes();
		bus_word_t r;
		bus_word_t v;
		bus_word_t expected;
		expected = data_bus_o;
		r = random_word();
		@(posedge MCLK2);
		ram_q_i <= r;
		ras0_n_i <= 1'b0;
		eoe_n_i <= 1'b0;
		@(posedge MCLK2);
		release_drivers();
		@(negedge MCLK2);
		expected = {r[15:8], expected[7:0]};
		check_value("ram high lane", 32'(expected), 32'(data_bus_o));

		r = random_word();
		@(posedge MCLK2);
		ram_q_i <= r;
		ras0_n_i <= 1'b0;
		noe_n_i <= 1'b0;
		@(posedge MCLK2);
		release_drivers();
		@(negedge MCLK2);
		expected = {expected[15:8], r[7:0]};
		check_value("ram low lane", 32'(expected), 32'(data_bus_o));

		// video and ram on the bus together
		r = random_word();
		v = random_word();
		@(posedge MCLK2);
		ram_q_i <= r;
		ras0_n_i <= 1'b0;
		eoe_n_i <= 1'b0;
		noe_n_i <= 1'b0;
		vdp_src_i.data <= v;
		vdp_src_i.drive_n <= 1'b0;
		@(posedge MCLK2);
		release_drivers();
		@(negedge MCLK2);
		check_value("video or ram", 32'(v | r), 32'(data_bus_o));
	endtask

	task automatic cart_mode();
		bus_word_t c;
		bus_word_t expected;
		int        cycles;
		expected = data_bus_o;
		c = random_word();
		c[15:8] = ~expected[15:8];
		@(posedge MCLK2);
		cart_data_i <= c;
		cart_data_en_i <= 1'b1;
		@(posedge MCLK2);
		release_drivers();
		@(negedge MCLK2);
		expected = {expected[15:8], c[7:0]};
		check_value("cart byte mode", 32'(expected), 32'(data_bus_o));

		// high byte must differ so the switch to word mode is visible
		c = random_word();
		c[15:8] = ~expected[15:8];
		@(posedge MCLK2);
		m3_i <= 1'b1;
		cart_data_i <= c;
		cart_data_en_i <= 1'b1;
		wait_for_bus("cart word mode", c, 8, cycles);
		check_value("cart mode latency", 32'd2, 32'(cycles));
		@(posedge MCLK2);
		release_drivers();
		m3_i <= 1'b0;
	endtask

	task automatic ram_port_map();
		logic [31:0] r;
		cpu_addr_t   va;
		logic        ia14;
		logic        uwr_n;
		logic        lwr_n;
		logic        ras0_n;
		bus_word_t   v;
		ram_addr_t   exp_addr;
		logic [1:0]  exp_be;
		logic        exp_wren;
		for (int i = 0; i < 24; i++)
		begin
			r = $random(seed);
			va = r[22:0];
			r = $random(seed);
			ia14 = r[0];
			uwr_n = r[1];
			lwr_n = r[2];
			ras0_n = r[3];
			v = random_word();
			@(posedge MCLK2);
			va_i <= va;
			ia14_i <= ia14;
			uwr_n_i <= uwr_n;
			lwr_n_i <= lwr_n;
			ras0_n_i <= ras0_n;
			// a fresh video word gives the write data to follow
			vdp_src_i.data <= v;
			vdp_src_i.drive_n <= 1'b0;
			@(posedge MCLK2);
			vdp_src_i.drive_n <= 1'b1;
			@(negedge MCLK2);
			exp_addr = va[14:0];
			exp_addr[13] = ia14;
			exp_be[1] = ~uwr_n;
			exp_be[0] = ~lwr_n;
			exp_wren = (!uwr_n || !lwr_n) && !ras0_n;
			check_value("ram address", 32'(exp_addr), 32'(ram_addr_o));
			check_value("ram byte enables", 32'(exp_be), 32'(ram_byteena_o));
			check_value("ram write enable", 32'(exp_wren), 32'(ram_wren_o));
			check_value("ram write data", 32'(v), 32'(ram_data_o));
			check_value("cart write data", 32'(v), 32'(cart_data_wr_o));
		end
		@(posedge MCLK2);
		uwr_n_i <= 1'b1;
		lwr_n_i <= 1'b1;
		ras0_n_i <= 1'b1;
	endtask

	task automatic mix_case(input fm_linear_t l, input fm_linear_t r,
		input fm_dac_t ld, input fm_dac_t rd, input psg_t p);
		@(posedge MCLK2);
		mol_i <= l;
		mor_i <= r;
		mol_dac_i <= ld;
		mor_dac_i <= rd;
		psg_i <= p;
		@(negedge MCLK2);
		check_value("audio linear left", 32'(linear_ref(l, p)), 32'(a_l_o));
		check_value("audio linear right", 32'(linear_ref(r, p)), 32'(a_r_o));
		check_value("audio dac left", 32'(dac_ref(ld, p)), 32'(a_l_dac_o));
		check_value("audio dac right", 32'(dac_ref(rd, p)), 32'(a_r_dac_o));
	endtask

	task automatic audio_mix();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		// range ends and midpoint
		mix_case(9'd0, 9'd511, 10'h200, 10'h1ff, 16'h0000);
		mix_case(9'd256, 9'd256, 10'h1ff, 10'h200, 16'hffff);
		mix_case(9'd511, 9'd0, 10'h000, 10'h3ff, 16'h8000);
		for (int i = 0; i < 16; i++)
		begin
			r1 = $random(seed);
			r2 = $random(seed);
			r3 = $random(seed);
			mix_case(r1[8:0], r1[24:16], r2[9:0], r2[25:16], r3[15:0]);
		end
	endtask

	initial
	begin
		seed = 30;
		errors = 0;
		checks = 0;
		rst_n_i <= 1'b0;
		vdp_src_i.data <= '0;
		vdp_src_i.drive_n <= 1'b1;
		cpu_src_i.data <= '0;
		cpu_src_i.drive_n <= 1'b1;
		ram_q_i <= '0;
		eoe_n_i <= 1'b1;
		noe_n_i <= 1'b1;
		ras0_n_i <= 1'b1;
		cart_data_i <= '0;
		cart_data_en_i <= 1'b0;
		m3_i <= 1'b0;
		va_i <= '0;
		ia14_i <= 1'b0;
		uwr_n_i <= 1'b1;
		lwr_n_i <= 1'b1;
		mol_i <= '0;
		mor_i <= '0;
		mol_dac_i <= '0;
		mor_dac_i <= '0;
		psg_i <= '0;

		// reset held for 8 clocks
		repeat (8) @(posedge MCLK2);
		rst_n_i <= 1'b1;

		reset_state();
		single_driver_hold();
		ram_byte_lanes();
		cart_mode();
		ram_port_map();
		audio_mix();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// watchdog against a stuck run
	initial
	begin
		repeat (2000) @(posedge MCLK2);
		$display("Timeout: simulation did not finish within 2000 clock cycles");
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+source
source/md_bus_pkg.sv
source/lane_enable_decode.sv
source/data_bus_lane.sv
source/work_ram_port.sv
source/audio_mixer.sv
source/md_bus_top.sv
verification/md_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the data-bus testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	-f files.f --top-module md_bus_tb \
	--Mdir "$BUILD_DIR" -o md_bus_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/md_bus_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi
